// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pcUplinkTb
FILELIST = vlog.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== logic/channelMerge.sv ====
`timescale 1ns/1ps

// fair two-input merge of packed host words
// winner goes into a one-word output register
module channelMerge import pcWordPkg::*, uplinkCtlPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  // input a
  input  pcWordT aData,
  input  logic   aValid,
  output logic   aAck,
  // input b
  input  pcWordT bData,
  input  logic   bValid,
  output logic   bAck,
  // merged output
  output pcWordT outData,
  output logic   outValid,
  input  logic   outAck
);

  mergePrioE prio;
  logic      grantA;
  logic      grantB;
  logic      canLoad;

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////
  // a lone request always wins, a tie goes to the pointer
  assign grantA = aValid && (!bValid || prio == preferA);
  assign grantB = bValid && (!aValid || prio == preferB);

  // register empty or emptying this cycle, so one word per cycle
  assign canLoad = !outValid || outAck;

  assign aAck = grantA && canLoad;
  assign bAck = grantB && canLoad;

  // pointer moves away from whichever input was just served
  always_ff @(posedge clk) begin
    if (!rstN) begin
      prio <= preferA;
    end else if (aAck) begin
      prio <= preferB;
    end else if (bAck) begin
      prio <= preferA;
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (aAck || bAck) begin
      outValid <= 1'b1;
    end else if (outAck) begin
      outValid <= 1'b0;
    end
  end

  // payload only, valid above says whether it counts
  always_ff @(posedge clk) begin
    if (aAck) begin
      outData <= aData;
    end else if (bAck) begin
      outData <= bData;
    end
  end

  // a stalled word stays put until the sink takes it
  assert property (@(posedge clk) disable iff (!rstN)
    (outValid && !outAck) |=> (outValid && $stable(outData)));

endmodule

// ==== logic/fpgaSerializer.sv ====
`timescale 1ns/1ps
`include "pcUplink_config.svh"

// serializes FPGA-generated traffic into 20-bit-data words
// a tag event or a heartbeat becomes a low word then a high word
module fpgaSerializer import pcWordPkg::*, uplinkCtlPkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  // filtered tag events
  input  logic                    tagValid,
  input  logic [`TAG_STATE_W-1:0] tagState,
  input  logic [`TAG_FILT_W-1:0]  tagFilt,
  output logic                    tagAck,
  // heartbeat requests from the time manager
  input  logic                    beatValid,
  input  logic [`TIME_W-1:0]      beatTime,
  output logic                    beatAck,
  // serialized words towards the packer
  serialWordIf.source             out
);

  serStateE               state;
  pcCodeE                 wordCode;
  logic [`PC_DATA_W-1:0]  lowWord;
  logic [`PC_DATA_W-1:0]  highWord;
  logic                   sent;

  ////////////////////////////////////////
  // input acceptance
  ////////////////////////////////////////
  // only idle takes a new event, heartbeat has priority over tags
  always_comb begin
    beatAck = (state == idle) && beatValid;
    tagAck  = (state == idle) && !beatValid && tagValid;
  end

  // a word leaves when valid and ack meet
  assign sent = out.valid && out.ack;

  // captured event, split into its two words at capture time
  // tag high word is filter index over the top state bits
  always_ff @(posedge clk) begin
    if (beatAck) begin
      lowWord  <= beatTime[`PC_DATA_W-1:0];
      highWord <= beatTime[`TIME_W-1:`PC_DATA_W];
    end else if (tagAck) begin
      lowWord  <= tagState[`PC_DATA_W-1:0];
      highWord <= {tagFilt, tagState[`TAG_STATE_W-1:`PC_DATA_W]};
    end
  end

  ////////////////////////////////////////
  // word sequencing FSM
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (beatValid) begin
            state <= beatLow;
          end else if (tagValid) begin
            state <= tagLow;
          end
        end
        // low word first, then the high word the cycle after it leaves
        tagLow: begin
          if (sent) begin
            state <= tagHigh;
          end
        end
        tagHigh: begin
          if (sent) begin
            state <= idle;
          end
        end
        beatLow: begin
          if (sent) begin
            state <= beatHigh;
          end
        end
        beatHigh: begin
          if (sent) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // code follows the state, both tag words share one code
  always_comb begin
    case (state)
      beatLow:  wordCode = codeBeatLow;
      beatHigh: wordCode = codeBeatHigh;
      default:  wordCode = codeTag;
    endcase
  end

  ////////////////////////////////////////
  // output channel
  ////////////////////////////////////////
  assign out.valid   = (state != idle);
  assign out.code    = wordCode;
  assign out.payload = (state == tagLow || state == beatLow) ? lowWord : highWord;
  // packer replaces this, kept as go-home for any other sink
  assign out.route   = `PC_GO_HOME_ROUTE;

  // an accepted event shows up as a valid word on the next cycle
  assert property (@(posedge clk) disable iff (!rstN)
    (tagAck || beatAck) |=> (out.valid && state != idle));

  // words are held under back-pressure, nothing changes before the ack
  assert property (@(posedge clk) disable iff (!rstN)
    (out.valid && !out.ack) |=>
      (out.valid && $stable(out.code) && $stable(out.payload)));

endmodule

// ==== logic/pcPacker.sv ====
`timescale 1ns/1ps
`include "pcUplink_config.svh"

// packs BD, FPGA and global word streams into host words
// then merges them in two registered stages
module pcPacker import pcWordPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  serialWordIf.sink  bdIn,
  serialWordIf.sink  fpgaIn,
  serialWordIf.sink  globalIn,
  output pcWordT     outData,
  output logic       outValid,
  input  logic       outAck
);

  pcWordT bdWord;
  pcWordT fpgaWord;
  pcWordT globalWord;
  pcWordT innerData;
  logic   innerValid;
  logic   innerAck;

  ////////////////////////////////////////
  // pack stage, purely combinational
  ////////////////////////////////////////
  // BD and FPGA always go home, their route field is ignored
  always_comb begin
    bdWord.route     = `PC_GO_HOME_ROUTE;
    bdWord.code      = bdIn.code;
    bdWord.data      = bdIn.payload;
    fpgaWord.route   = `PC_GO_HOME_ROUTE;
    fpgaWord.code    = fpgaIn.code;
    fpgaWord.data    = fpgaIn.payload;
    // global words already carry their destination
    globalWord.route = globalIn.route;
    globalWord.code  = globalIn.code;
    globalWord.data  = globalIn.payload;
  end

  ////////////////////////////////////////
  // two-level merge
  ////////////////////////////////////////
  // inner stage joins BD and FPGA traffic
  channelMerge u_innerMerge (
    .clk      (clk),
    .rstN     (rstN),
    .aData    (bdWord),
    .aValid   (bdIn.valid),
    .aAck     (bdIn.ack),
    .bData    (fpgaWord),
    .bValid   (fpgaIn.valid),
    .bAck     (fpgaIn.ack),
    .outData  (innerData),
    .outValid (innerValid),
    .outAck   (innerAck)
  );

  // root stage adds global traffic, one register deeper
  channelMerge u_rootMerge (
    .clk      (clk),
    .rstN     (rstN),
    .aData    (innerData),
    .aValid   (innerValid),
    .aAck     (innerAck),
    .bData    (globalWord),
    .bValid   (globalIn.valid),
    .bAck     (globalIn.ack),
    .outData  (outData),
    .outValid (outValid),
    .outAck   (outAck)
  );

  // BD funnel only produces leaf codes, the FPGA range above must stay free
  assert property (@(posedge clk) disable iff (!rstN)
    bdIn.valid |-> (bdIn.code <= `PC_CODE_W'(`BD_MAX_CODE)));

endmodule

// ==== logic/pcUplink.sv ====
`timescale 1ns/1ps
`include "pcUplink_config.svh"

// upward path from FPGA to host PC
// BD words, FPGA-generated events and global tag words in, host words out
module pcUplink (
  input  logic                    clk,
  input  logic                    rstN,
  // BD serializer words
  input  logic [`PC_CODE_W-1:0]   bdCode,
  input  logic [`PC_DATA_W-1:0]   bdPayload,
  input  logic                    bdValid,
  output logic                    bdAck,
  // filtered tag events
  input  logic                    tagValid,
  input  logic [`TAG_STATE_W-1:0] tagState,
  input  logic [`TAG_FILT_W-1:0]  tagFilt,
  output logic                    tagAck,
  // heartbeat requests
  input  logic                    beatValid,
  input  logic [`TIME_W-1:0]      beatTime,
  output logic                    beatAck,
  // global tag parser words, route already set
  input  logic [`PC_ROUTE_W-1:0]  globalRoute,
  input  logic [`PC_CODE_W-1:0]   globalCode,
  input  logic [`PC_DATA_W-1:0]   globalPayload,
  input  logic                    globalValid,
  output logic                    globalAck,
  // host words
  output logic [`PC_WORD_W-1:0]   pcData,
  output logic                    pcValid,
  input  logic                    pcAck
);

  serialWordIf bdCh ();
  serialWordIf fpgaCh ();
  serialWordIf globalCh ();

  // BD port onto its channel
  assign bdCh.code         = bdCode;
  assign bdCh.payload      = bdPayload;
  assign bdCh.route        = `PC_GO_HOME_ROUTE;
  assign bdCh.valid        = bdValid;
  assign bdAck             = bdCh.ack;

  // global port onto its channel
  assign globalCh.code     = globalCode;
  assign globalCh.payload  = globalPayload;
  assign globalCh.route    = globalRoute;
  assign globalCh.valid    = globalValid;
  assign globalAck         = globalCh.ack;

  // FPGA traffic is serialized here, adding one cycle before packing
  fpgaSerializer u_fpgaSerializer (
    .clk       (clk),
    .rstN      (rstN),
    .tagValid  (tagValid),
    .tagState  (tagState),
    .tagFilt   (tagFilt),
    .tagAck    (tagAck),
    .beatValid (beatValid),
    .beatTime  (beatTime),
    .beatAck   (beatAck),
    .out       (fpgaCh.source)
  );

  pcPacker u_pcPacker (
    .clk      (clk),
    .rstN     (rstN),
    .bdIn     (bdCh.sink),
    .fpgaIn   (fpgaCh.sink),
    .globalIn (globalCh.sink),
    .outData  (pcData),
    .outValid (pcValid),
    .outAck   (pcAck)
  );

endmodule

// ==== logic/pcUplink_config.svh ====
`ifndef PC_UPLINK_CONFIG_SVH
`define PC_UPLINK_CONFIG_SVH

////////////////////////////////////////
// host word fields, msb to lsb
////////////////////////////////////////
`define PC_ROUTE_W 5
`define PC_CODE_W 7
`define PC_DATA_W 20
`define PC_WORD_W (`PC_ROUTE_W + `PC_CODE_W + `PC_DATA_W)

// all ones in the route field sends a word to the host
`define PC_GO_HOME_ROUTE 5'h1f

// fpga-side event widths
`define TAG_STATE_W 27
`define TAG_FILT_W 13
`define TIME_W 40

// codes 0 to 13 are BD funnel leaves, FPGA traffic sits just above
`define BD_MAX_CODE 13
`define FPGA_MIN_CODE 14
`define FPGA_MAX_CODE 16

`endif

// ==== logic/pcWordPkg.sv ====
`include "pcUplink_config.svh"

package pcWordPkg;

  ////////////////////////////////////////
  // host word layout
  ////////////////////////////////////////
  // [ route | code | data ]
  // BD and FPGA words share one code space
  // there is no separate BD/FPGA flag bit

  // codes the FPGA generates itself
  // BD codes 0 to BD_MAX_CODE are cast in as plain numbers
  typedef enum logic [`PC_CODE_W-1:0] {
    // filtered tag, sent as two words with the same code
    codeTag      = `FPGA_MIN_CODE,
    // heartbeat time bits 19 to 0
    codeBeatLow  = `FPGA_MIN_CODE + 1,
    // heartbeat time bits 39 to 20
    codeBeatHigh = `FPGA_MAX_CODE
  } pcCodeE;

  // one packed 32-bit word towards the host
  typedef struct packed {
    // destination; go-home for BD and FPGA traffic
    logic [`PC_ROUTE_W-1:0] route;
    // BD leaf code or a pcCodeE value
    logic [`PC_CODE_W-1:0]  code;
    // one 20-bit chunk of payload, lsbs sent first
    logic [`PC_DATA_W-1:0]  data;
  } pcWordT;

  // tag high word carries filter index over state bits 26 to 20
  // heartbeat words carry 20 bits of time each

endpackage

// ==== logic/serialWordIf.sv ====
`timescale 1ns/1ps
`include "pcUplink_config.svh"

// serialized word channel, valid/ack handshake
// payload is one 20-bit chunk, route only matters for global traffic
interface serialWordIf;

  logic [`PC_CODE_W-1:0]  code;
  logic [`PC_DATA_W-1:0]  payload;
  logic [`PC_ROUTE_W-1:0] route;
  logic                   valid;
  logic                   ack;

  // producer holds code, payload and route until valid and ack meet
  modport source (
    output code,
    output payload,
    output route,
    output valid,
    input  ack
  );

  // consumer may raise ack as a function of valid
  modport sink (
    input  code,
    input  payload,
    input  route,
    input  valid,
    output ack
  );

endinterface

// ==== logic/uplinkCtlPkg.sv ====
package uplinkCtlPkg;

  ////////////////////////////////////////
  // fpga serializer FSM
  ////////////////////////////////////////
  // idle accepts one event, then two words go out in order
  typedef enum logic [2:0] {
    idle,
    tagLow,
    tagHigh,
    beatLow,
    beatHigh
  } serStateE;

  ////////////////////////////////////////
  // merge arbiter
  ////////////////////////////////////////
  // round-robin pointer, names the input that wins a tie
  typedef enum logic {
    preferA,
    preferB
  } mergePrioE;

endpackage

// ==== verif/pcUplinkTb.sv ====
`timescale 1ns/1ps
`include "pcUplink_config.svh"

module pcUplinkTb;

  // one stimulus row, src is 0 BD, 1 tag, 2 heartbeat, 3 global
  // aux holds the BD or global code, or the tag filter index
  typedef struct packed {
    logic [1:0]  src;
    logic [39:0] val;
    logic [12:0] aux;
    logic [4:0]  route;
    logic [7:0]  gap;
    logic        timed;
    logic        mixed;
  } rowT;

  logic clk;
  logic rstN;
  logic [6:0] bdCode;
  logic [19:0] bdPayload;
  logic bdValid;
  logic bdAck;
  logic tagValid;
  logic tagAck;
  logic [26:0] tagState;
  logic [12:0] tagFilt;
  logic beatValid;
  logic beatAck;
  logic [39:0] beatTime;
  logic [4:0] globalRoute;
  logic [6:0] globalCode;
  logic [19:0] globalPayload;
  logic globalValid;
  logic globalAck;
  logic [31:0] pcData;
  logic pcValid;
  logic pcAck;

  rowT rows[$];
  // expected words per stream, with the due cycle or -1 when untimed
  logic [31:0] bdQ[$];
  logic [31:0] fpgaQ[$];
  logic [31:0] globalQ[$];
  int bdDue[$];
  int fpgaDue[$];
  int globalDue[$];
  integer seed;
  int errors;
  int cycle;
  int limit;
  logic mixStarted;

  pcUplink u_pcUplink (.*);

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  task automatic addRow(input rowT r);
    rows.push_back(r);
  endtask

  task automatic buildTable();
    rowT r;
    // directed rows, spaced so the BD word and heartbeat run alone
    addRow('{2'd0, 40'h00000abcde, 13'h0005, 5'h00, 8'd0, 1'b1, 1'b0});
    addRow('{2'd3, 40'h0000012345, 13'h002a, 5'h03, 8'd8, 1'b0, 1'b0});
    // tag and heartbeat launch together
    addRow('{2'd2, 40'h9876543210, 13'h0000, 5'h00, 8'd16, 1'b1, 1'b0});
    addRow('{2'd1, 40'h0005a5a5a5, 13'h1abc, 5'h00, 8'd16, 1'b0, 1'b0});
    // mixed traffic, global routes never go home
    repeat (24) begin
      r.src   = 2'($unsigned($random(seed)) % 4);
      r.val   = 40'({$random(seed), $random(seed)});
      r.aux   = 13'($random(seed));
      r.route = 5'($unsigned($random(seed)) % 31);
      r.gap   = 8'($unsigned($random(seed)) % 4);
      r.timed = 1'b0;
      r.mixed = 1'b1;
      if (r.src == 2'd0) begin
        r.aux = 13'($unsigned($random(seed)) % 14);
      end
      addRow(r);
    end
  endtask

  ////////////////////////////////////////
  // drivers, one process per source
  ////////////////////////////////////////
  function automatic logic ackOf(input logic [1:0] src);
    case (src)
      2'd0: return bdAck;
      2'd1: return tagAck;
      2'd2: return beatAck;
      default: return globalAck;
    endcase
  endfunction

  // host words follow route(5) code(7) data(20)
  // tag words use code 14, heartbeat words 15 then 16
  task automatic expectWords(input rowT r, input int now);
    case (r.src)
      2'd0: begin
        bdQ.push_back({`PC_GO_HOME_ROUTE, r.aux[6:0], r.val[19:0]});
        bdDue.push_back(r.timed ? now + 2 : -1);
      end
      2'd1: begin
        fpgaQ.push_back({`PC_GO_HOME_ROUTE, 7'd14, r.val[19:0]});
        fpgaQ.push_back({`PC_GO_HOME_ROUTE, 7'd14, r.aux, r.val[26:20]});
        fpgaDue.push_back(-1);
        fpgaDue.push_back(-1);
      end
      2'd2: begin
        // low word leaves three cycles after capture when nothing stalls
        fpgaQ.push_back({`PC_GO_HOME_ROUTE, 7'd15, r.val[19:0]});
        fpgaQ.push_back({`PC_GO_HOME_ROUTE, 7'd16, r.val[39:20]});
        fpgaDue.push_back(r.timed ? now + 3 : -1);
        fpgaDue.push_back(-1);
      end
      default: begin
        globalQ.push_back({r.route, r.aux[6:0], r.val[19:0]});
        globalDue.push_back(-1);
      end
    endcase
  endtask

  task automatic driveSource(input logic [1:0] src);
    rowT r;
    foreach (rows[i]) begin
      r = rows[i];
      if (r.src == src) begin
        if (r.mixed && !mixStarted) begin
          wait (mixStarted);
        end
        repeat (r.gap) @(negedge clk);
        case (src)
          2'd0: begin
            bdCode = r.aux[6:0];
            bdPayload = r.val[19:0];
            bdValid = 1'b1;
          end
          2'd1: begin
            tagState = r.val[26:0];
            tagFilt = r.aux;
            tagValid = 1'b1;
          end
          2'd2: begin
            beatTime = r.val;
            beatValid = 1'b1;
          end
          default: begin
            globalRoute = r.route;
            globalCode = r.aux[6:0];
            globalPayload = r.val[19:0];
            globalValid = 1'b1;
          end
        endcase
        // hold valid until the cycle it meets ack
        do @(posedge clk); while (!ackOf(src));
        expectWords(r, cycle);
        @(negedge clk);
        case (src)
          2'd0: bdValid = 1'b0;
          2'd1: tagValid = 1'b0;
          2'd2: beatValid = 1'b0;
          default: globalValid = 1'b0;
        endcase
      end
    end
  endtask

  ////////////////////////////////////////
  // output monitor and scoreboard
  ////////////////////////////////////////
  always @(posedge clk) begin
    logic [31:0] expWord;
    int expDue;
    logic found;
    found = 1'b0;
    if (!rstN) begin
      if (cycle >= 2) begin
        assert (!pcValid && !bdAck && !tagAck && !beatAck && !globalAck) else begin
          errors++;
          $display("FAIL {pcValid,bdAck,tagAck,beatAck,globalAck} got %h expected %h",
                   {pcValid, bdAck, tagAck, beatAck, globalAck}, 5'h00);
        end
      end
    end else begin
      // a waiting heartbeat is taken before a tag
      if (tagValid && beatValid) begin
        assert (!tagAck) else begin
          errors++;
          $display("FAIL tagAck got %h expected %h", tagAck, 1'b0);
        end
      end
      if (pcValid && pcAck) begin
        // route picks global, code picks BD or FPGA
        if (pcData[31:27] != `PC_GO_HOME_ROUTE && globalQ.size() > 0) begin
          expWord = globalQ.pop_front();
          expDue = globalDue.pop_front();
          found = 1'b1;
        end else if (pcData[31:27] == `PC_GO_HOME_ROUTE && pcData[26:20] <= 7'd13
                     && bdQ.size() > 0) begin
          expWord = bdQ.pop_front();
          expDue = bdDue.pop_front();
          found = 1'b1;
        end else if (pcData[31:27] == `PC_GO_HOME_ROUTE && pcData[26:20] >= 7'd14
                     && pcData[26:20] <= 7'd16 && fpgaQ.size() > 0) begin
          expWord = fpgaQ.pop_front();
          expDue = fpgaDue.pop_front();
          found = 1'b1;
        end
        assert (found) else begin
          errors++;
          $display("host word %h matches no pending word of any source", pcData);
        end
        if (found) begin
          assert (pcData == expWord) else begin
            errors++;
            $display("FAIL pcData got %h expected %h", pcData, expWord);
          end
          if (expDue >= 0) begin
            assert (cycle == expDue) else begin
              errors++;
              $display("FAIL pcData arrival cycle got %h expected %h", cycle, expDue);
            end
          end
        end
      end
    end
  end

  // random back-pressure once mixed traffic starts, about 70 percent high
  always @(negedge clk) begin
    if (mixStarted) begin
      pcAck = (($random(seed) & 32'hff) < 179);
    end
  end

  // cycle count and run limit
  always @(negedge clk) begin
    cycle++;
    if (cycle > limit) begin
      $display("timeout after %0d cycles with %0d errors", cycle, errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    seed = 65559;
    clk = 1'b0;
    rstN = 1'b0;
    {bdCode, bdPayload, bdValid} = '0;
    {tagValid, tagState, tagFilt} = '0;
    {beatValid, beatTime} = '0;
    {globalRoute, globalCode, globalPayload, globalValid} = '0;
    pcAck = 1'b1;
    mixStarted = 1'b0;
    errors = 0;
    cycle = 0;
    buildTable();
    limit = 30 * rows.size() + 200;
    repeat (10) @(negedge clk);
    rstN = 1'b1;
    fork
      driveSource(2'd0);
      driveSource(2'd1);
      driveSource(2'd2);
      driveSource(2'd3);
      begin
        repeat (50) @(negedge clk);
        mixStarted = 1'b1;
      end
    join
    while (bdQ.size() + fpgaQ.size() + globalQ.size() != 0) begin
      @(negedge clk);
    end
    // a few idle cycles so any extra word is caught
    repeat (8) @(negedge clk);
    assert (!pcValid) else begin
      errors++;
      $display("FAIL pcValid got %h expected %h", pcValid, 1'b0);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/pcWordPkg.sv
logic/uplinkCtlPkg.sv
logic/serialWordIf.sv
logic/fpgaSerializer.sv
logic/channelMerge.sv
logic/pcPacker.sv
logic/pcUplink.sv
verif/pcUplinkTb.sv
